/* verilog/hostBus_settings.svh */
`ifndef HOST_BUS_SETTINGS_SVH
`define HOST_BUS_SETTINGS_SVH

// Bus widths
`define HB_ADDR_W    25
`define HB_DATA_W    32
`define HB_LANES     4
`define HB_LANE_W    8
`define SMPC_ADDR_W  6

// Region select field, addr[24:20]
`define REG_SEL_HI   24
`define REG_SEL_LO   20
`define REG_ROM      5'd0
`define REG_SMPC     5'd1
`define REG_SRAM     5'd2
`define REG_RAML     5'd3
`define REG_OPEN_LO  5'd4
`define REG_OPEN_HI  5'd7
`define REG_SCU_LO   5'd8
`define REG_SCU_HI   5'd15
`define REG_RAMH_LO  5'd16
`define REG_RAMH_HI  5'd31

`endif

/* verilog/hostBusPkg.sv */
`include "hostBus_settings.svh"

package hostBusPkg;

	typedef logic [`HB_DATA_W-1:0] hbWord;
	typedef logic [`HB_ADDR_W-1:0] hbAddr;
	typedef logic [`HB_LANES-1:0]  laneMaskN;  // Low = lane active

	typedef enum logic [2:0] {
		ROM,
		SMPC,
		SRAM,
		RAML,
		SCU,
		RAMH,
		OPEN
	} busRegion;

	// Take active lanes from newData, the rest from oldData
	function automatic hbWord laneMerge(input hbWord newData, input hbWord oldData,
	                                    input laneMaskN maskN);
		hbWord res;
		res = oldData;
		for (int i = 0; i < `HB_LANES; i++) begin
			if (!maskN[i])
				res[i*`HB_LANE_W +: `HB_LANE_W] = newData[i*`HB_LANE_W +: `HB_LANE_W];
		end
		return res;
	endfunction

endpackage

/* verilog/cycleDecoder.sv */
`timescale 1ns/1ps
`include "hostBus_settings.svh"

module cycleDecoder import hostBusPkg::*; (
	input  logic     CLK,
	input  logic     RST_N,

	input  logic     req,
	output logic     ack,
	input  hbAddr    addr,
	input  logic     rd,
	input  laneMaskN dqmN,
	input  hbWord    wdata,
	output hbWord    rdata,
	input  logic     dbgPause,

	output logic     cycValid,
	output busRegion cycRegion,
	output hbAddr    cycAddr,
	output logic     cycRd,
	output laneMaskN cycDqmN,
	output hbWord    cycWdata,

	input  logic     doneValid,
	input  hbWord    doneData
);

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		ACKED
	} decState;

	decState state;
	logic    accept;

	function automatic busRegion decodeRegion(input hbAddr a);
		logic [`REG_SEL_HI-`REG_SEL_LO:0] sel;
		sel = a[`REG_SEL_HI:`REG_SEL_LO];
		case (sel) inside
			`REG_ROM:                       return ROM;
			`REG_SMPC:                      return SMPC;
			`REG_SRAM:                      return SRAM;
			`REG_RAML:                      return RAML;
			[`REG_OPEN_LO:`REG_OPEN_HI]:    return OPEN;
			[`REG_SCU_LO:`REG_SCU_HI]:      return SCU;
			[`REG_RAMH_LO:`REG_RAMH_HI]:    return RAMH;
			default:                        return OPEN;
		endcase
	endfunction

	assign accept = (state == IDLE) && req && !dbgPause;  // Held off while paused

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= IDLE;
			cycValid  <= 1'b0;
			ack       <= 1'b0;
			cycRegion <= OPEN;
			cycRd     <= 1'b0;
		end else begin
			cycValid <= 1'b0;
			case (state)
				IDLE: if (accept) begin
					cycValid  <= 1'b1;
					cycRegion <= decodeRegion(addr);
					cycRd     <= rd;
					state     <= BUSY;
				end
				BUSY: if (doneValid) begin
					ack   <= 1'b1;
					state <= ACKED;
				end
				ACKED: if (!req) begin  // Four-phase release
					ack   <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			cycAddr  <= addr;
			cycDqmN  <= dqmN;
			cycWdata <= wdata;
		end
		if (doneValid)
			rdata <= doneData;
	end

	// Host must keep req up until the cycle is acknowledged
	assert property (@(posedge CLK) disable iff (!RST_N)
		(state == BUSY && !ack) |-> req);

endmodule

/* verilog/targetAccess.sv */
`timescale 1ns/1ps
`include "hostBus_settings.svh"

module targetAccess import hostBusPkg::*; (
	input  logic                     CLK,
	input  logic                     RST_N,

	input  logic                     cycValid,
	input  busRegion                 cycRegion,
	input  hbAddr                    cycAddr,
	input  logic                     cycRd,
	input  laneMaskN                 cycDqmN,
	input  hbWord                    cycWdata,

	input  hbWord                    openBus,

	output logic                     rspValid,
	output logic                     rspRd,
	output laneMaskN                 rspDqmN,
	output hbWord                    rspData,

	output hbAddr                    memA,
	input  hbWord                    memDi,
	output hbWord                    memDo,
	output laneMaskN                 memDqmN,
	output logic                     memRd,
	output logic                     romCsN,
	output logic                     sramCsN,
	output logic                     ramlCsN,
	output logic                     ramhCsN,
	input  logic                     memWaitN,

	output logic                     smpcCsN,
	output logic                     smpcRwN,
	output logic [`SMPC_ADDR_W-1:0]  smpcA,
	output logic [7:0]               smpcDi,
	input  logic [7:0]               smpcDo,

	output logic                     scuCsN,
	output hbAddr                    scuA,
	output logic                     scuRdN,
	output hbWord                    scuDi,
	output laneMaskN                 scuDqmN,
	input  hbWord                    scuDo,
	input  logic                     scuWaitN
);

	logic  holding;  // Stretched by wait states
	logic  active;
	logic  memSel;
	logic  smpcSel;
	logic  scuSel;
	logic  waitOk;
	hbWord wrWord;
	hbWord rdWord;

	assign active  = cycValid | holding;
	assign memSel  = active && (cycRegion inside {ROM, SRAM, RAML, RAMH});
	assign smpcSel = active && (cycRegion == SMPC);
	assign scuSel  = active && (cycRegion == SCU);

	// Inactive lanes carry the open-bus value
	assign wrWord = laneMerge(cycWdata, openBus, cycDqmN);

	always_comb begin
		case (cycRegion)
			ROM, SRAM, RAML, RAMH: begin
				waitOk = memWaitN;
				rdWord = memDi;
			end
			SMPC: begin
				waitOk = 1'b1;  // Fixed single cycle
				rdWord = {16'h0000, 8'hFF, smpcDo};
			end
			SCU: begin
				waitOk = scuWaitN;
				rdWord = scuDo;
			end
			default: begin
				waitOk = 1'b1;
				rdWord = openBus;  // Unmapped
			end
		endcase
	end

	assign memA    = cycAddr;
	assign memDo   = wrWord;
	assign memDqmN = memSel ? cycDqmN : '1;
	assign memRd   = memSel && cycRd;
	assign romCsN  = !(active && cycRegion == ROM);
	assign sramCsN = !(active && cycRegion == SRAM);
	assign ramlCsN = !(active && cycRegion == RAML);
	assign ramhCsN = !(active && cycRegion == RAMH);

	assign smpcCsN = !smpcSel;
	assign smpcRwN = !(smpcSel && !cycRd);
	assign smpcA   = cycAddr[`SMPC_ADDR_W:1];
	assign smpcDi  = wrWord[7:0];  // Byte port on lane 0

	assign scuCsN  = !scuSel;
	assign scuA    = cycAddr;
	assign scuRdN  = !(scuSel && cycRd);
	assign scuDi   = wrWord;
	assign scuDqmN = scuSel ? cycDqmN : '1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			holding  <= 1'b0;
			rspValid <= 1'b0;
		end else begin
			rspValid <= active && waitOk;
			holding  <= active && !waitOk;
		end
	end

	always_ff @(posedge CLK) begin
		if (active && waitOk) begin
			rspRd   <= cycRd;
			rspDqmN <= cycDqmN;
			rspData <= cycRd ? rdWord : wrWord;
		end
	end

	// No new cycle arrives while a target is held
	assert property (@(posedge CLK) disable iff (!RST_N)
		holding |-> !cycValid);

endmodule

/* verilog/openBusLatch.sv */
`timescale 1ns/1ps

module openBusLatch import hostBusPkg::*; (
	input  logic     CLK,
	input  logic     RST_N,

	input  logic     rspValid,
	input  logic     rspRd,
	input  laneMaskN rspDqmN,
	input  hbWord    rspData,

	output hbWord    openBus,

	output logic     doneValid,
	output hbWord    doneData
);

	hbWord openBusR;
	hbWord openBusNext;

	// Reads replace the whole word, writes only their active lanes
	always_comb begin
		openBusNext = openBusR;
		if (rspValid) begin
			if (rspRd)
				openBusNext = rspData;
			else
				openBusNext = laneMerge(rspData, openBusR, rspDqmN);
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			openBusR  <= '1;  // Floating bus reads high
			doneValid <= 1'b0;
		end else begin
			openBusR  <= openBusNext;
			doneValid <= rspValid;
		end
	end

	// Every cycle returns the bus value it leaves behind
	always_ff @(posedge CLK) begin
		if (rspValid)
			doneData <= openBusNext;
	end

	assign openBus = openBusR;

	// One response per host cycle
	assert property (@(posedge CLK) disable iff (!RST_N)
		rspValid |=> !rspValid);

endmodule

/* verilog/hostBusGlue.sv */
`timescale 1ns/1ps
`include "hostBus_settings.svh"

module hostBusGlue import hostBusPkg::*; (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     dbgPause,

	// Host
	input  logic                     req,
	output logic                     ack,
	input  hbAddr                    addr,
	input  logic                     rd,
	input  laneMaskN                 dqmN,
	input  hbWord                    wdata,
	output hbWord                    rdata,

	// External memory
	output hbAddr                    memA,
	input  hbWord                    memDi,
	output hbWord                    memDo,
	output laneMaskN                 memDqmN,
	output logic                     memRd,
	output logic                     romCsN,
	output logic                     sramCsN,
	output logic                     ramlCsN,
	output logic                     ramhCsN,
	input  logic                     memWaitN,

	// SMPC
	output logic                     smpcCsN,
	output logic                     smpcRwN,
	output logic [`SMPC_ADDR_W-1:0]  smpcA,
	output logic [7:0]               smpcDi,
	input  logic [7:0]               smpcDo,

	// SCU
	output logic                     scuCsN,
	output hbAddr                    scuA,
	output logic                     scuRdN,
	output hbWord                    scuDi,
	output laneMaskN                 scuDqmN,
	input  hbWord                    scuDo,
	input  logic                     scuWaitN
);

	logic     cycValid;
	busRegion cycRegion;
	hbAddr    cycAddr;
	logic     cycRd;
	laneMaskN cycDqmN;
	hbWord    cycWdata;

	logic     rspValid;
	logic     rspRd;
	laneMaskN rspDqmN;
	hbWord    rspData;

	hbWord    openBus;
	logic     doneValid;
	hbWord    doneData;

	cycleDecoder u_cycleDecoder (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.req       (req),
		.ack       (ack),
		.addr      (addr),
		.rd        (rd),
		.dqmN      (dqmN),
		.wdata     (wdata),
		.rdata     (rdata),
		.dbgPause  (dbgPause),
		.cycValid  (cycValid),
		.cycRegion (cycRegion),
		.cycAddr   (cycAddr),
		.cycRd     (cycRd),
		.cycDqmN   (cycDqmN),
		.cycWdata  (cycWdata),
		.doneValid (doneValid),
		.doneData  (doneData)
	);

	targetAccess u_targetAccess (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cycValid  (cycValid),
		.cycRegion (cycRegion),
		.cycAddr   (cycAddr),
		.cycRd     (cycRd),
		.cycDqmN   (cycDqmN),
		.cycWdata  (cycWdata),
		.openBus   (openBus),
		.rspValid  (rspValid),
		.rspRd     (rspRd),
		.rspDqmN   (rspDqmN),
		.rspData   (rspData),
		.memA      (memA),
		.memDi     (memDi),
		.memDo     (memDo),
		.memDqmN   (memDqmN),
		.memRd     (memRd),
		.romCsN    (romCsN),
		.sramCsN   (sramCsN),
		.ramlCsN   (ramlCsN),
		.ramhCsN   (ramhCsN),
		.memWaitN  (memWaitN),
		.smpcCsN   (smpcCsN),
		.smpcRwN   (smpcRwN),
		.smpcA     (smpcA),
		.smpcDi    (smpcDi),
		.smpcDo    (smpcDo),
		.scuCsN    (scuCsN),
		.scuA      (scuA),
		.scuRdN    (scuRdN),
		.scuDi     (scuDi),
		.scuDqmN   (scuDqmN),
		.scuDo     (scuDo),
		.scuWaitN  (scuWaitN)
	);

	openBusLatch u_openBusLatch (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.rspValid  (rspValid),
		.rspRd     (rspRd),
		.rspDqmN   (rspDqmN),
		.rspData   (rspData),
		.openBus   (openBus),
		.doneValid (doneValid),
		.doneData  (doneData)
	);

endmodule

/* verif/hostBusTb.sv */
`timescale 1ns/1ps
`include "hostBus_settings.svh"

module hostBusTb import hostBusPkg::*; ();

	localparam int TIMEOUT = 200;  // Cycles per wait loop

	logic                    CLK;
	logic                    RST_N;
	logic                    dbgPause;
	logic                    req;
	logic                    ack;
	hbAddr                   addr;
	logic                    rd;
	laneMaskN                dqmN;
	hbWord                   wdata;
	hbWord                   rdata;
	hbAddr                   memA;
	hbWord                   memDi;
	hbWord                   memDo;
	laneMaskN                memDqmN;
	logic                    memRd;
	logic                    romCsN;
	logic                    sramCsN;
	logic                    ramlCsN;
	logic                    ramhCsN;
	logic                    memWaitN;
	logic                    smpcCsN;
	logic                    smpcRwN;
	logic [`SMPC_ADDR_W-1:0] smpcA;
	logic [7:0]              smpcDi;
	logic [7:0]              smpcDo;
	logic                    scuCsN;
	hbAddr                   scuA;
	logic                    scuRdN;
	hbWord                   scuDi;
	laneMaskN                scuDqmN;
	hbWord                   scuDo;
	logic                    scuWaitN;

	int    errors;
	int    passed;
	int    failed;
	bit    aborted;
	hbWord openBusModel;  // Predicted open-bus register

	hostBusGlue u_hostBusGlue (.*);

	always #4 CLK = ~CLK;

	task automatic checkValue(input string testName, input string what, input hbWord expVal,
	                          input hbWord actVal);
		if (expVal !== actVal) begin
			$display("MISMATCH %s (%s): expected %h, actual %h", testName, what, expVal, actVal);
			errors++;
		end
	endtask

	// Lanes with dqmN low come from newData
	function automatic hbWord mergeLanes(input hbWord newData, input hbWord oldData,
	                                     input laneMaskN maskN);
		hbWord keep;
		for (int i = 0; i < `HB_LANES; i++)
			keep[i*8 +: 8] = {8{maskN[i]}};
		return (newData & ~keep) | (oldData & keep);
	endfunction

	// Bits are {rom, sram, raml, ramh, smpc, scu}
	function automatic logic [5:0] expectedSelects(input hbAddr a);
		logic [4:0] top;
		top = a[24:20];
		if (top >= 16)
			return 6'b000100;
		if (top >= 8)
			return 6'b000001;
		if (top >= 4)
			return 6'b000000;  // Unmapped
		case (top[1:0])
			2'd0:    return 6'b100000;
			2'd1:    return 6'b000010;
			2'd2:    return 6'b010000;
			default: return 6'b001000;
		endcase
	endfunction

	task automatic runTest(input string testName, input string op, input hbAddr tAddr,
	                       input laneMaskN tDqmN, input hbWord tWdata, input hbWord tVal,
	                       input int waits, input int pause, input hbWord expVal);
		int         cycles;
		int         waited;
		int         errBefore;
		bit         isRead;
		bit         ackInWait;
		logic [5:0] csSeen;
		hbWord      observed;
		hbWord      predicted;
		hbWord      merged;
		hbAddr      seenAddr;
		laneMaskN   seenDqmN;
		logic       seenRd;
		isRead    = (op == "R");
		errBefore = errors;
		cycles    = 0;
		waited    = 0;
		ackInWait = 1'b0;
		csSeen    = '0;
		observed  = 'x;
		seenAddr  = 'x;
		seenDqmN  = 'x;
		seenRd    = 1'bx;
		@(posedge CLK);
		memDi    <= (waits > 0) ? ~tVal : tVal;  // Junk until release
		scuDo    <= (waits > 0) ? ~tVal : tVal;
		smpcDo   <= tVal[7:0];
		memWaitN <= (waits == 0);
		scuWaitN <= (waits == 0);
		addr     <= tAddr;
		rd       <= isRead;
		dqmN     <= tDqmN;
		wdata    <= tWdata;
		dbgPause <= (pause > 0);
		req      <= 1'b1;
		while (!ack && cycles < TIMEOUT) begin
			@(posedge CLK);
			cycles++;
			if (cycles == pause)
				dbgPause <= 1'b0;
			csSeen |= ~{romCsN, sramCsN, ramlCsN, ramhCsN, smpcCsN, scuCsN};
			if (!memWaitN || !scuWaitN) begin
				ackInWait |= ack;
				if (!romCsN || !sramCsN || !ramlCsN || !ramhCsN || !scuCsN) begin
					waited++;
					if (waited == waits) begin  // Release with the real data
						memWaitN <= 1'b1;
						scuWaitN <= 1'b1;
						memDi    <= tVal;
						scuDo    <= tVal;
					end
				end
			end else if (!romCsN || !sramCsN || !ramlCsN || !ramhCsN) begin
				observed = memDo;
				seenAddr = memA;
				seenDqmN = memDqmN;
				seenRd   = memRd;
			end else if (!scuCsN) begin
				observed = scuDi;
				seenAddr = scuA;
				seenDqmN = scuDqmN;
				seenRd   = !scuRdN;
			end else if (!smpcCsN) begin
				observed = {24'h000000, smpcDi};
				seenAddr = smpcA;
				seenRd   = smpcRwN;  // High for a read
			end
		end
		if (!ack) begin
			$display("TIMEOUT in %s: ack did not rise within %0d cycles", testName, TIMEOUT);
			errors++;
			aborted = 1'b1;
		end else begin
			merged = mergeLanes(tWdata, openBusModel, tDqmN);
			case (expectedSelects(tAddr))
				6'b000000: predicted = openBusModel;
				6'b000010: predicted = isRead ? {16'h0000, 8'hFF, tVal[7:0]}
				                              : {24'h000000, merged[7:0]};
				default:   predicted = isRead ? tVal : merged;
			endcase
			if (isRead)
				observed = rdata;
			checkValue(testName, "file value", expVal, observed);
			checkValue(testName, "model value", predicted, observed);
			checkValue(testName, "chip selects", expectedSelects(tAddr), csSeen);
			if (expectedSelects(tAddr) != 6'b000000) begin  // Target port contents
				checkValue(testName, "target address",
				           (expectedSelects(tAddr) == 6'b000010) ? tAddr[`SMPC_ADDR_W:1]
				                                                 : tAddr,
				           seenAddr);
				checkValue(testName, "target read", isRead, seenRd);
				if (expectedSelects(tAddr) != 6'b000010)
					checkValue(testName, "target dqmN", tDqmN, seenDqmN);
			end
			checkValue(testName, "req to ack cycles", 4 + waits + pause, cycles - 1);
			if (ackInWait) begin
				$display("ERROR in %s: ack rose while a wait input was low", testName);
				errors++;
			end
			openBusModel = isRead ? predicted : merged;  // Reads whole, writes by lane
			req <= 1'b0;
			cycles = 0;
			while (ack && cycles < TIMEOUT) begin
				@(posedge CLK);
				cycles++;
			end
			if (ack) begin
				$display("TIMEOUT in %s: ack stayed high after req fell", testName);
				errors++;
				aborted = 1'b1;
			end
		end
		memWaitN <= 1'b1;
		scuWaitN <= 1'b1;
		dbgPause <= 1'b0;
		if (errors == errBefore) begin
			passed++;
			$display("PASS %s", testName);
		end else begin
			failed++;
			$display("FAIL %s", testName);
		end
	endtask

	initial begin
		int       fd;
		int       n;
		string    line;
		string    testName;
		string    op;
		hbAddr    tAddr;
		laneMaskN tDqmN;
		hbWord    tWdata;
		hbWord    tVal;
		int       waits;
		int       pause;
		hbWord    expVal;
		CLK          = 1'b0;
		RST_N        = 1'b0;
		dbgPause     = 1'b0;
		req          = 1'b0;
		addr         = '0;
		rd           = 1'b0;
		dqmN         = '1;
		wdata        = '0;
		memDi        = '0;
		memWaitN     = 1'b1;
		smpcDo       = '0;
		scuDo        = '0;
		scuWaitN     = 1'b1;
		errors       = 0;
		passed       = 0;
		failed       = 0;
		aborted      = 1'b0;
		openBusModel = '1;  // All ones out of reset
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;
		fd = $fopen("verif/hostBusTestdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file verif/hostBusTestdata.txt");
			errors++;
		end else begin
			while (!aborted && $fgets(line, fd) > 0) begin
				n = $sscanf(line, "%s %s %h %h %h %h %d %d %h", testName, op, tAddr, tDqmN,
				            tWdata, tVal, waits, pause, expVal);
				if (n == 9 && line[0] != "#")
					runTest(testName, op, tAddr, tDqmN, tWdata, tVal, waits, pause, expVal);
			end
			$fclose(fd);
		end
		$display("Tests passed: %0d, failed: %0d, errors: %0d", passed, failed, errors);
		if (errors == 0 && passed > 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* verif/hostBusTestdata.txt */
# name op(R/W) addr dqmN wdata targetValue waits pause expected
# addr, dqmN, wdata, targetValue and expected in hex; waits and pause in decimal cycles
openRst       R 0400000 0 00000000 00000000 0 0 FFFFFFFF
romRd         R 0000100 0 00000000 12345678 0 0 12345678
sramRd        R 0200040 0 00000000 A5A55A5A 0 0 A5A55A5A
ramlRd        R 0300080 0 00000000 0BADF00D 0 0 0BADF00D
ramhRd        R 1000010 0 00000000 CAFEBABE 0 0 CAFEBABE
ramhWrPart    W 1000020 C 11223344 00000000 0 0 CAFE3344
openAfterWr   R 0500000 0 00000000 00000000 0 0 CAFE3344
ramlWrPart    W 0300004 5 AABBCCDD 00000000 0 0 AAFECC44
openMix       R 0480000 0 00000000 00000000 0 0 AAFECC44
romWait       R 0000200 0 00000000 DEADBEEF 3 0 DEADBEEF
scuRd         R 0800010 0 00000000 00C0FFEE 0 0 00C0FFEE
scuWait       R 0F00020 0 00000000 13579BDF 2 0 13579BDF
scuWrPart     W 0800040 E FFFFFF42 00000000 1 0 13579B42
smpcRd        R 010001E 0 00000000 0000005C 0 0 0000FF5C
smpcWr        W 0100002 E 000000A7 00000000 0 0 000000A7
openAfterSmpc R 0600000 0 00000000 00000000 0 0 0000FFA7
pauseRd       R 1800000 0 00000000 76543210 0 5 76543210
pauseWaitWr   W 0200008 0 89ABCDEF 00000000 2 3 89ABCDEF
sramWrPart    W 0200010 7 5A000000 00000000 0 0 5AABCDEF
openAfterSram R 0700000 0 00000000 00000000 0 0 5AABCDEF
ramhWait      R 1FFFFFC 0 00000000 02468ACE 4 0 02468ACE
scuWrFull     W 0C00000 0 01020304 00000000 0 0 01020304
openLast      R 0400004 0 00000000 00000000 0 0 01020304

/* hostBusGlue.f */
+incdir+verilog
verilog/hostBusPkg.sv
verilog/cycleDecoder.sv
verilog/targetAccess.sv
verilog/openBusLatch.sv
verilog/hostBusGlue.sv
verif/hostBusTb.sv
